// ==== osd_consts.svh ====
// overlay geometry is fixed at build time; OSD_W must stay a multiple of 8 and fit the RAM
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// top left corner of the overlay, in active pixels
`define OSD_X0 12'd9
`define OSD_Y0 12'd9

// overlay size, width in whole glyph bytes
`define OSD_W 12'd152
`define OSD_H 12'd33

// rgb565 value drawn where a glyph bit is set
`define OSD_KEY_COLOR 16'hF800

// glyph RAM address width, 2048 bytes
`define OSD_RAM_AW 11

// i_video to o_video, in pclk cycles
`define OSD_LATENCY 4

`endif

// ==== osd_pkg.sv ====
// shared stream types; video is one rgb565 pixel per pclk with active high hs, vs and de
`include "osd_consts.svh"

package osd_pkg;

	// one pixel beat as it travels down the pipeline
	typedef struct packed
	{
		logic        hs;
		logic        vs;
		logic        de;     // pixel strobe
		logic [15:0] data;   // rgb565
	} video_beat_t;

	// active pixel coordinates, 0 based
	typedef struct packed
	{
		logic [11:0] x;
		logic [11:0] y;
	} pix_xy_t;

	// host write of one glyph byte
	typedef struct packed
	{
		logic [`OSD_RAM_AW-1:0] addr;
		logic [7:0]             data;   // bit 0 is the leftmost pixel
	} glyph_wr_t;

endpackage

// ==== osd_delay_line.sv ====
// fixed depth register delay for any packed payload; DEPTH must be at least 1, clears to zero
module osd_delay_line
#(
	parameter type T     = logic,
	parameter int  DEPTH = 1
)
(
	input  logic pclk,
	input  logic i_arst_n,
	input  T     i_d,
	output T     o_q
);

	T stage_q [DEPTH];   // stage 0 nearest the input

	always_ff @(posedge pclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= i_d;
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1];   // shift one stage per pclk
		end
	end

	assign o_q = stage_q[DEPTH-1];

endmodule

// ==== osd_timing_xy.sv ====
// vs is active high and restarts y; x and y are 12 bit, so lines and frames stay below 4096
module osd_timing_xy import osd_pkg::*;
(
	input  logic        pclk,
	input  logic        i_arst_n,
	input  video_beat_t i_video,
	output video_beat_t o_video,
	output pix_xy_t     o_xy
);

	logic [11:0] x_cnt;     // index of the next de pixel in this line
	logic [11:0] y_cnt;     // completed active lines in this frame
	logic        de_prev;
	logic        vs_prev;
	logic        de_fall;
	logic        vs_rise;

	// the registered beat already holds last cycle's de and vs
	assign de_prev = o_video.de;
	assign vs_prev = o_video.vs;
	assign de_fall = de_prev && !i_video.de;
	assign vs_rise = !vs_prev && i_video.vs;

	always_ff @(posedge pclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_video <= '0;
			o_xy    <= '0;
			x_cnt   <= '0;
			y_cnt   <= '0;
		end
		else
		begin
			o_video <= i_video;
			o_xy.x  <= x_cnt;
			o_xy.y  <= y_cnt;

			if (i_video.de)
				x_cnt <= x_cnt + 12'd1;
			else
				x_cnt <= '0;   // cleared through blanking

			if (vs_rise)
				y_cnt <= '0;   // new frame
			else if (de_fall)
				y_cnt <= y_cnt + 12'd1;   // line finished
		end
	end

	// a line longer than 4096 pixels would wrap x back into the overlay
	a_x_no_wrap: assert property (@(posedge pclk) disable iff (!i_arst_n)
		i_video.de && de_prev |-> x_cnt != '0)
		else $error("x counter wrapped inside an active line");

endmodule

// ==== osd_glyph_ram.sv ====
// single clock 2048 x 8 RAM on pclk; a read of the address being written returns the old byte
`include "osd_consts.svh"

module osd_glyph_ram import osd_pkg::*;
(
	input  logic                   pclk,
	input  logic                   i_we,
	input  glyph_wr_t              i_wr,
	input  logic [`OSD_RAM_AW-1:0] i_rd_addr,
	output logic [7:0]             o_rd_data
);

	localparam int DEPTH = 1 << `OSD_RAM_AW;

	logic [7:0] mem [DEPTH];   // glyph bytes, kept across reset

	always_ff @(posedge pclk)
	begin
		if (i_we)
			mem[i_wr.addr] <= i_wr.data;
	end

	// registered read, one cycle from address to data
	always_ff @(posedge pclk)
	begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// ==== osd_glyph_fetch.sv ====
// glyph bit is valid 2 cycles after i_xy; bitmap rows are packed with no padding, lsb first
`include "osd_consts.svh"

module osd_glyph_fetch import osd_pkg::*;
(
	input  logic      pclk,
	input  logic      i_arst_n,
	input  logic      i_de,
	input  pix_xy_t   i_xy,
	input  pix_xy_t   i_xy_d,       // i_xy one cycle later, for checking
	input  logic      i_glyph_we,
	input  glyph_wr_t i_glyph_wr,
	output logic      o_glyph_bit
);

	logic [11:0]            x_off;
	logic [11:0]            y_off;
	logic [23:0]            lin_addr;     // bit offset into the bitmap
	logic                   in_region;
	logic                   region_q;
	logic                   region_qq;
	logic [`OSD_RAM_AW-1:0] addr_q;
	logic [2:0]             bit_q;
	logic [2:0]             bit_qq;
	logic [7:0]             rd_data;
	logic [23:0]            chk_off;

	assign x_off     = i_xy.x - `OSD_X0;
	assign y_off     = i_xy.y - `OSD_Y0;
	assign lin_addr  = 24'(y_off) * 24'(`OSD_W) + 24'(x_off);
	assign in_region = i_de
		&& (i_xy.x >= `OSD_X0) && (i_xy.x < `OSD_X0 + `OSD_W)
		&& (i_xy.y >= `OSD_Y0) && (i_xy.y < `OSD_Y0 + `OSD_H);

	// cycle 2, region flag
	always_ff @(posedge pclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			region_q  <= 1'b0;
			region_qq <= 1'b0;
		end
		else
		begin
			region_q  <= in_region;
			region_qq <= region_q;   // lines up with RAM data
		end
	end

	// cycle 2, byte address and bit index
	always_ff @(posedge pclk)
	begin
		addr_q <= lin_addr[`OSD_RAM_AW+2:3];
		bit_q  <= x_off[2:0];
		bit_qq <= bit_q;
	end

	osd_glyph_ram u_osd_glyph_ram
	(
		.pclk      (pclk),
		.i_we      (i_glyph_we),
		.i_wr      (i_glyph_wr),
		.i_rd_addr (addr_q),
		.o_rd_data (rd_data)
	);

	// cycle 3
	assign o_glyph_bit = region_qq && rd_data[bit_qq];

	// full width byte address rebuilt from the coordinates that produced addr_q
	assign chk_off = (24'(i_xy_d.y - `OSD_Y0) * 24'(`OSD_W) + 24'(i_xy_d.x - `OSD_X0)) >> 3;

	a_addr_in_ram: assert property (@(posedge pclk) disable iff (!i_arst_n)
		region_q |-> chk_off < (24'd1 << `OSD_RAM_AW))
		else $error("overlay byte address outside the glyph RAM");

endmodule

// ==== osd_pixel_mixer.sv ====
// single colour keying only; sync and de pass unchanged, output registered and cleared on reset
`include "osd_consts.svh"

module osd_pixel_mixer import osd_pkg::*;
(
	input  logic        pclk,
	input  logic        i_arst_n,
	input  video_beat_t i_video,
	input  logic        i_glyph_bit,
	output video_beat_t o_video
);

	video_beat_t mix;

	always_comb
	begin
		mix = i_video;
		if (i_glyph_bit)
			mix.data = `OSD_KEY_COLOR;   // glyph pixel
	end

	always_ff @(posedge pclk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_video <= '0;
		else
			o_video <= mix;   // cycle 4
	end

	// glyph bit and beat come from different paths and must stay aligned
	a_key_only_active: assert property (@(posedge pclk) disable iff (!i_arst_n)
		i_glyph_bit |-> i_video.de)
		else $error("key colour forced outside active video");

endmodule

// ==== osd_overlay_top.sv ====
// glyph writes share pclk with video; no back pressure, every beat leaves OSD_LATENCY cycles later
`include "osd_consts.svh"

module osd_overlay_top import osd_pkg::*;
(
	input  logic        pclk,
	input  logic        i_arst_n,
	input  video_beat_t i_video,
	input  logic        i_glyph_we,
	input  glyph_wr_t   i_glyph_wr,
	output video_beat_t o_video
);

	video_beat_t dec_video;   // cycle 1
	pix_xy_t     dec_xy;      // cycle 1
	pix_xy_t     xy_d;        // cycle 2
	video_beat_t mix_in;      // cycle 3
	logic        glyph_bit;   // cycle 3

	osd_timing_xy u_osd_timing_xy
	(
		.pclk     (pclk),
		.i_arst_n (i_arst_n),
		.i_video  (i_video),
		.o_video  (dec_video),
		.o_xy     (dec_xy)
	);

	osd_delay_line #(.T(pix_xy_t), .DEPTH(1)) u_xy_delay
	(
		.pclk     (pclk),
		.i_arst_n (i_arst_n),
		.i_d      (dec_xy),
		.o_q      (xy_d)
	);

	osd_glyph_fetch u_osd_glyph_fetch
	(
		.pclk        (pclk),
		.i_arst_n    (i_arst_n),
		.i_de        (dec_video.de),
		.i_xy        (dec_xy),
		.i_xy_d      (xy_d),
		.i_glyph_we  (i_glyph_we),
		.i_glyph_wr  (i_glyph_wr),
		.o_glyph_bit (glyph_bit)
	);

	// decode and mixer registers take two of the total latency
	osd_delay_line #(.T(video_beat_t), .DEPTH(`OSD_LATENCY - 2)) u_beat_delay
	(
		.pclk     (pclk),
		.i_arst_n (i_arst_n),
		.i_d      (dec_video),
		.o_q      (mix_in)
	);

	osd_pixel_mixer u_osd_pixel_mixer
	(
		.pclk        (pclk),
		.i_arst_n    (i_arst_n),
		.i_video     (mix_in),
		.i_glyph_bit (glyph_bit),
		.o_video     (o_video)
	);

endmodule

// ==== tb_osd_overlay.sv ====
// self checking testbench; 200 x 48 active frames, whole glyph RAM loaded before the first frame
`include "osd_consts.svh"

module tb_osd_overlay import osd_pkg::*;
();

	localparam int H_ACTIVE   = 200;
	localparam int V_ACTIVE   = 48;
	localparam int H_BLANK    = 12;
	localparam int N_FRAMES   = 3;
	localparam int WAIT_LIMIT = 5000;

	typedef struct packed
	{
		video_beat_t beat;
		logic        key;   // glyph pixel expected
	} exp_t;

	logic        pclk;
	logic        i_arst_n;
	video_beat_t i_video;
	logic        i_glyph_we;
	glyph_wr_t   i_glyph_wr;
	video_beat_t o_video;

	logic [7:0]  glyph_mirror [1 << `OSD_RAM_AW];
	exp_t        exp_q [$];
	exp_t        exp_head;          // expected o_video for this cycle
	int          x_m;
	int          y_m;
	logic        de_m_prev;
	logic        vs_m_prev;
	int          post_rst_cycles;
	int          out_lines;         // completed active lines seen on o_video
	logic        out_de_prev;

	osd_overlay_top u_osd_overlay_top
	(
		.pclk       (pclk),
		.i_arst_n   (i_arst_n),
		.i_video    (i_video),
		.i_glyph_we (i_glyph_we),
		.i_glyph_wr (i_glyph_wr),
		.o_video    (o_video)
	);

	initial
	begin
		pclk = 1'b0;
		forever #5 pclk = ~pclk;
	end

	// expected beat from the overlay rules
	function automatic exp_t expect_pixel(input video_beat_t beat, input int x, input int y);
		exp_t e;
		int   off;
		e.beat = beat;
		e.key  = 1'b0;
		if (beat.de && x >= `OSD_X0 && x < `OSD_X0 + `OSD_W
			&& y >= `OSD_Y0 && y < `OSD_Y0 + `OSD_H)
		begin
			off   = (y - `OSD_Y0) * `OSD_W + (x - `OSD_X0);
			e.key = glyph_mirror[off / 8][(x - `OSD_X0) % 8];   // lsb is leftmost
		end
		if (e.key)
			e.beat.data = `OSD_KEY_COLOR;
		return e;
	endfunction

	// reference model on the input side
	always @(posedge pclk)
	begin
		if (!i_arst_n)
		begin
			x_m             = 0;
			y_m             = 0;
			de_m_prev       = 1'b0;
			vs_m_prev       = 1'b0;
			post_rst_cycles = 0;
			exp_q.delete();
			repeat (`OSD_LATENCY)
				exp_q.push_back('0);
			exp_head = '0;
		end
		else
		begin
			if (i_glyph_we)
				glyph_mirror[i_glyph_wr.addr] = i_glyph_wr.data;
			exp_q.push_back(expect_pixel(i_video, x_m, y_m));
			void'(exp_q.pop_front());
			exp_head = exp_q[0];   // beat that entered 3 edges ago
			if (i_video.de)
				x_m = x_m + 1;
			else
				x_m = 0;
			if (i_video.vs && !vs_m_prev)
				y_m = 0;   // new frame
			else if (!i_video.de && de_m_prev)
				y_m = y_m + 1;
			de_m_prev = i_video.de;
			vs_m_prev = i_video.vs;
			if (post_rst_cycles < 1000)
				post_rst_cycles++;
		end
	end

	always @(negedge pclk)
	begin
		if (!i_arst_n)
		begin
			out_lines   = 0;
			out_de_prev = 1'b0;
		end
		else
		begin
			if (out_de_prev && !o_video.de)
				out_lines++;
			out_de_prev = o_video.de;
		end
	end

	task automatic report_mismatch(input string what, input video_beat_t got,
		input video_beat_t exp);
		$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
		$display("TEST FAILED");
		$fatal(1, "o_video check failed");
	endtask

	a_reset_idle: assert property (@(posedge pclk) disable iff (!i_arst_n)
		post_rst_cycles < `OSD_LATENCY |-> o_video == '0)
		else report_mismatch("output not idle after reset", $sampled(o_video), '0);

	a_sync_delay: assert property (@(posedge pclk) disable iff (!i_arst_n)
		{o_video.hs, o_video.vs, o_video.de}
			== {exp_head.beat.hs, exp_head.beat.vs, exp_head.beat.de})
		else report_mismatch("hs, vs or de misaligned", $sampled(o_video),
			$sampled(exp_head.beat));

	a_pass_through: assert property (@(posedge pclk) disable iff (!i_arst_n)
		!exp_head.key |-> o_video.data == exp_head.beat.data)
		else report_mismatch("source pixel changed", $sampled(o_video),
			$sampled(exp_head.beat));

	a_key_colour: assert property (@(posedge pclk) disable iff (!i_arst_n)
		exp_head.key |-> o_video.data == `OSD_KEY_COLOR)
		else report_mismatch("glyph pixel not keyed", $sampled(o_video),
			$sampled(exp_head.beat));

	task automatic drive_beat(input logic hs, input logic vs, input logic de);
		@(posedge pclk);
		#1;
		i_video    = {hs, vs, de, 16'($urandom)};
		i_glyph_we = 1'b0;
	endtask

	task automatic write_glyph(input logic [`OSD_RAM_AW-1:0] addr, input logic [7:0] data);
		@(posedge pclk);
		#1;
		i_video    = '0;
		i_glyph_we = 1'b1;
		i_glyph_wr = {addr, data};
	endtask

	task automatic drive_line(input logic vs, input logic active);
		for (int i = 0; i < H_BLANK; i++)
			drive_beat(i < 4, vs, 1'b0);   // hs pulse at line start
		for (int i = 0; i < H_ACTIVE; i++)
			drive_beat(1'b0, vs, active);
	endtask

	task automatic drive_frame();
		repeat (2) drive_line(1'b1, 1'b0);   // vs pulse
		repeat (2) drive_line(1'b0, 1'b0);
		repeat (V_ACTIVE) drive_line(1'b0, 1'b1);
		repeat (2) drive_line(1'b0, 1'b0);   // front porch
	endtask

	// inverts the corner bytes of the bitmap and one random byte
	task automatic flip_glyph_bytes();
		int row_bytes;
		int last;
		int pick;
		row_bytes = int'(`OSD_W) / 8;
		last      = int'(`OSD_W) * int'(`OSD_H) / 8 - 1;
		pick      = $urandom_range(last);
		write_glyph(11'(0), ~glyph_mirror[0]);
		write_glyph(11'(row_bytes - 1), ~glyph_mirror[row_bytes - 1]);
		write_glyph(11'(last - row_bytes + 1), ~glyph_mirror[last - row_bytes + 1]);
		write_glyph(11'(last), ~glyph_mirror[last]);
		write_glyph(11'(pick), ~glyph_mirror[pick]);
	endtask

	task automatic wait_lines_out(input int target);
		int cycles;
		cycles = 0;
		while (out_lines < target && cycles < WAIT_LIMIT)
		begin
			@(posedge pclk);
			cycles++;
		end
		if (out_lines < target)
		begin
			$display("timed out after %0d cycles waiting for %0d output lines", cycles, target);
			$display("TEST FAILED");
			$fatal(1, "output frame did not complete");
		end
	endtask

	initial
	begin
		void'($urandom(32'hb988_ba45));
		i_arst_n   = 1'b0;
		i_video    = {1'b1, 1'b1, 1'b1, 16'($urandom)};   // busy beat held through reset
		i_glyph_we = 1'b0;
		i_glyph_wr = '0;
		repeat (4) @(posedge pclk);
		#1;
		i_arst_n = 1'b1;
		i_video  = '0;

		for (int a = 0; a < (1 << `OSD_RAM_AW); a++)
			write_glyph(a[`OSD_RAM_AW-1:0], 8'($urandom));

		for (int f = 1; f <= N_FRAMES; f++)
		begin
			drive_frame();
			wait_lines_out(f * V_ACTIVE);
			if (f == 1)
				flip_glyph_bytes();   // seen in frame 2 only at those bytes
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
osd_pkg.sv
osd_delay_line.sv
osd_timing_xy.sv
osd_glyph_ram.sv
osd_glyph_fetch.sv
osd_pixel_mixer.sv
osd_overlay_top.sv
tb_osd_overlay.sv
